// File: common/ppu_macros.svh
`ifndef PPU_MACROS_SVH
`define PPU_MACROS_SVH

// raster geometry
`define PPU_DOTS        341
`define PPU_LINES       262
`define PPU_VIS_W       256
`define PPU_VIS_H       240
`define PPU_VBL_LINE    241
`define PPU_PRE_LINE    261

// next line prefetch window and vertical reload window
`define PPU_PREF_START  321
`define PPU_PREF_END    336
`define PPU_VRST_START  280
`define PPU_VRST_END    304

// control and mask bits
`define PPU_CTRL_INC    2
`define PPU_CTRL_BGPT   4
`define PPU_CTRL_NMI    7
`define PPU_MASK_BG     3

`endif

// File: common/ppu_pkg.sv
package ppu_pkg;

    // cpu visible register map
    typedef enum logic [2:0] {
        REG_CTRL    = 3'd0,
        REG_MASK    = 3'd1,
        REG_STATUS  = 3'd2,
        REG_OAMADDR = 3'd3,
        REG_OAMDATA = 3'd4,
        REG_SCROLL  = 3'd5,
        REG_ADDR    = 3'd6,
        REG_DATA    = 3'd7
    } ppu_reg_e;

    // loopy layout yyy NN YYYYY XXXXX
    typedef struct packed {
        logic [2:0] fine_y;
        logic [1:0] nt;       // bit 0 horizontal, bit 1 vertical
        logic [4:0] coarse_y;
        logic [4:0] coarse_x;
    } ppu_scroll_t;

    typedef struct packed {
        logic        pad;
        logic [13:0] addr;
    } ppu_vaddr_t;

    // same 15 bits, seen as scroll or as vram address
    typedef union packed {
        ppu_scroll_t s;
        ppu_vaddr_t  a;
    } ppu_vaddr_u;

    typedef struct packed {
        logic       cs;
        logic       rw;       // 1 = read
        ppu_reg_e   addr;
        logic [7:0] wdata;
    } cpu_bus_t;

    typedef struct packed {
        logic [13:0] addr;
        logic        rd;
        logic        wr;
        logic [7:0]  wdata;
    } vram_bus_t;

    typedef struct packed {
        logic        nt;
        logic        attr;
        logic        pat;
        logic [13:0] pat_addr;
    } fetch_req_t;

    typedef struct packed {
        logic inc_x;
        logic inc_y;
        logic reset_x;
        logic reset_y;
    } scroll_step_t;

    // one fetched tile, handed from fetch to shifter
    typedef struct packed {
        logic [7:0] lo;
        logic [7:0] hi;
        logic [1:0] attr;
    } bg_tile_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] idx;
    } bg_pix_t;

    typedef struct packed {
        logic       sel;
        logic       wr;
        logic [4:0] addr;
        logic [7:0] data;
    } pal_port_t;

endpackage

// File: hdl/palette_out.sv
`timescale 1ns/1ps

module palette_out import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bg_pix_t    pix_i,
    input  pal_port_t  pal_i,
    output logic [7:0] pal_rdata_o,
    output logic [7:0] px_data_o,
    output logic       px_valid_o
);
    logic [7:0] mem_q [32];
    logic [4:0] cpu_addr;
    logic [4:0] pix_addr;
    logic [4:0] rd_addr;

    // 10/14/18/1C alias 00/04/08/0C
    assign cpu_addr = (pal_i.addr[1:0] == 2'b00) ? {1'b0, pal_i.addr[3:0]} : pal_i.addr;
    // transparent pixels show the backdrop
    assign pix_addr = (pix_i.idx[1:0] == 2'b00) ? 5'd0 : pix_i.idx;
    assign rd_addr  = pal_i.sel ? cpu_addr : pix_addr;

    assign pal_rdata_o = mem_q[rd_addr];

    always_ff @(posedge clk) begin
        if (pal_i.sel && pal_i.wr) mem_q[cpu_addr] <= pal_i.data;
        px_data_o <= pal_rdata_o;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            px_valid_o <= 1'b0;
        end else begin
            px_valid_o <= pix_i.valid;
        end
    end

endmodule

// File: hdl/ppu_regs.sv
`timescale 1ns/1ps
`include "ppu_macros.svh"

module ppu_regs import ppu_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  cpu_bus_t     cpu_i,
    output logic [7:0]   cpu_data_o,
    output vram_bus_t    vram_o,
    input  logic [7:0]   vram_data_i,
    input  fetch_req_t   fetch_i,
    input  scroll_step_t step_i,
    input  logic         vblank_i,
    output ppu_vaddr_u   v_o,
    output logic [2:0]   fine_x_o,
    output logic [7:0]   ctrl_o,
    output logic [7:0]   mask_o,
    output pal_port_t    pal_o,
    input  logic [7:0]   pal_rdata_i,
    output logic         nmi_o
);
    logic        cs_q;
    logic        rd_acc;
    logic        wr_acc;
    ppu_vaddr_u  v_q;
    ppu_vaddr_u  t_q;
    logic [2:0]  fine_x_q;
    logic [7:0]  ctrl_q;
    logic [7:0]  mask_q;
    logic        w_q;        // second write of a pair
    logic [7:0]  latch_q;    // cpu side io latch
    logic [7:0]  rbuf_q;
    logic        wr_q;
    logic        pal_wr_q;
    logic        buf_ld_q;
    logic        inc_q;
    logic        vbl_q;
    logic        nmi_occ_q;
    logic        vbl_rise;
    logic        vbl_fall;
    logic        in_pal;
    logic [7:0]  status;
    logic [13:0] attr_addr;
    logic [13:0] nt_addr;

    // one access per rising edge of the select
    assign rd_acc   = cpu_i.cs & ~cs_q & cpu_i.rw;
    assign wr_acc   = cpu_i.cs & ~cs_q & ~cpu_i.rw;
    assign vbl_rise = vblank_i & ~vbl_q;
    assign vbl_fall = ~vblank_i & vbl_q;
    assign in_pal   = (v_q.a.addr[13:8] == 6'h3F) && vblank_i;
    assign status   = {nmi_occ_q | vbl_rise, 2'b00, latch_q[4:0]};  // no sprite flags

    always_ff @(posedge clk) begin
        if (rst) begin
            cs_q      <= 1'b0;
            vbl_q     <= 1'b0;
            nmi_occ_q <= 1'b0;
            wr_q      <= 1'b0;
            pal_wr_q  <= 1'b0;
            buf_ld_q  <= 1'b0;
            inc_q     <= 1'b0;
            w_q       <= 1'b0;
            ctrl_q    <= 8'h00;
            mask_q    <= 8'h00;
            v_q       <= '0;
            t_q       <= '0;
            fine_x_q  <= 3'd0;
            latch_q   <= 8'h00;
            rbuf_q    <= 8'h00;
        end else begin
            cs_q     <= cpu_i.cs;
            vbl_q    <= vblank_i;
            wr_q     <= 1'b0;
            pal_wr_q <= 1'b0;
            buf_ld_q <= 1'b0;
            inc_q    <= 1'b0;

            if (vbl_rise) begin
                nmi_occ_q <= 1'b1;
            end else if (vbl_fall) begin
                nmi_occ_q <= 1'b0;
            end
            if (buf_ld_q) rbuf_q <= vram_data_i;  // address still holds old v

            if (rd_acc) begin
                case (cpu_i.addr)
                    REG_STATUS: begin
                        latch_q   <= status;
                        nmi_occ_q <= 1'b0;
                        w_q       <= 1'b0;
                    end
                    REG_DATA: begin
                        latch_q  <= in_pal ? pal_rdata_i : rbuf_q;
                        buf_ld_q <= 1'b1;
                        inc_q    <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            if (wr_acc) begin
                latch_q <= cpu_i.wdata;
                case (cpu_i.addr)
                    REG_CTRL: begin
                        ctrl_q   <= cpu_i.wdata;
                        t_q.s.nt <= cpu_i.wdata[1:0];
                    end
                    REG_MASK: mask_q <= cpu_i.wdata;
                    REG_SCROLL: begin
                        if (!w_q) begin
                            t_q.s.coarse_x <= cpu_i.wdata[7:3];
                            fine_x_q       <= cpu_i.wdata[2:0];
                        end else begin
                            t_q.s.coarse_y <= cpu_i.wdata[7:3];
                            t_q.s.fine_y   <= cpu_i.wdata[2:0];
                        end
                        w_q <= ~w_q;
                    end
                    REG_ADDR: begin
                        if (!w_q) begin
                            t_q.a.pad        <= 1'b0;
                            t_q.a.addr[13:8] <= cpu_i.wdata[5:0];
                        end else begin
                            t_q.a.addr[7:0] <= cpu_i.wdata;
                            v_q.a <= {t_q.a.pad, t_q.a.addr[13:8], cpu_i.wdata};
                        end
                        w_q <= ~w_q;
                    end
                    REG_DATA: begin
                        pal_wr_q <= in_pal;
                        wr_q     <= ~in_pal;
                        inc_q    <= 1'b1;
                    end
                    default: begin
                    end
                endcase
            end

            if (inc_q) v_q <= v_q + (ctrl_q[`PPU_CTRL_INC] ? 15'd32 : 15'd1);

            if (step_i.inc_y) begin
                if (&v_q.s.fine_y) begin
                    if (v_q.s.coarse_y == 5'd29) begin  // bottom row, next table down
                        v_q.s.coarse_y <= 5'd0;
                        v_q.s.nt[1]    <= ~v_q.s.nt[1];
                    end else begin
                        v_q.s.coarse_y <= v_q.s.coarse_y + 5'd1;  // 31 wraps without flip
                    end
                end
                v_q.s.fine_y <= v_q.s.fine_y + 3'd1;
            end

            if (step_i.inc_x) begin
                if (&v_q.s.coarse_x) v_q.s.nt[0] <= ~v_q.s.nt[0];
                v_q.s.coarse_x <= v_q.s.coarse_x + 5'd1;
            end

            if (step_i.reset_x) begin
                v_q.s.nt[0]    <= t_q.s.nt[0];
                v_q.s.coarse_x <= t_q.s.coarse_x;
            end

            if (step_i.reset_y) begin
                v_q.s.nt[1]    <= t_q.s.nt[1];
                v_q.s.coarse_y <= t_q.s.coarse_y;
                v_q.s.fine_y   <= t_q.s.fine_y;
            end
        end
    end

    // attribute table sits at 23C0 of each nametable
    assign attr_addr = {2'b10, v_q.s.nt, 4'b1111, v_q.s.coarse_y[4:2], v_q.s.coarse_x[4:2]};
    assign nt_addr   = {2'b10, v_q.a.addr[11:0]};

    always_comb begin
        if (fetch_i.attr) begin
            vram_o.addr = attr_addr;
        end else if (fetch_i.pat) begin
            vram_o.addr = fetch_i.pat_addr;
        end else if (fetch_i.nt) begin
            vram_o.addr = nt_addr;
        end else begin
            vram_o.addr = v_q.a.addr;
        end
        vram_o.wr    = wr_q;
        vram_o.rd    = ~wr_q;
        vram_o.wdata = latch_q;
    end

    assign pal_o.sel  = in_pal;
    assign pal_o.wr   = pal_wr_q;
    assign pal_o.addr = v_q.a.addr[4:0];
    assign pal_o.data = latch_q;

    assign nmi_o      = nmi_occ_q & ctrl_q[`PPU_CTRL_NMI];
    assign cpu_data_o = latch_q;
    assign v_o        = v_q;
    assign fine_x_o   = fine_x_q;
    assign ctrl_o     = ctrl_q;
    assign mask_o     = mask_q;

endmodule

// File: hdl/ppu_top.sv
`timescale 1ns/1ps

module ppu_top import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  cpu_bus_t   cpu_i,
    output logic [7:0] cpu_data_o,
    output vram_bus_t  vram_o,
    input  logic [7:0] vram_data_i,
    output logic [7:0] px_data_o,
    output logic       px_valid_o,
    output logic       nmi_o,
    output logic       vblank_o
);
    fetch_req_t   fetch;
    scroll_step_t step;
    ppu_vaddr_u   v;
    logic [2:0]   fine_x;
    logic [7:0]   ctrl;
    logic [7:0]   mask;
    pal_port_t    pal;
    logic [7:0]   pal_rdata;
    logic         load;
    bg_tile_t     tile;
    logic         active;
    bg_pix_t      pix;

    ppu_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cpu_i       (cpu_i),
        .cpu_data_o  (cpu_data_o),
        .vram_o      (vram_o),
        .vram_data_i (vram_data_i),
        .fetch_i     (fetch),
        .step_i      (step),
        .vblank_i    (vblank_o),
        .v_o         (v),
        .fine_x_o    (fine_x),
        .ctrl_o      (ctrl),
        .mask_o      (mask),
        .pal_o       (pal),
        .pal_rdata_i (pal_rdata),
        .nmi_o       (nmi_o)
    );

    bg_fetch u_fetch (
        .clk         (clk),
        .rst         (rst),
        .v_i         (v),
        .ctrl_i      (ctrl),
        .mask_i      (mask),
        .vram_data_i (vram_data_i),
        .fetch_o     (fetch),
        .step_o      (step),
        .load_o      (load),
        .tile_o      (tile),
        .active_o    (active),
        .vblank_o    (vblank_o)
    );

    bg_shifter u_shifter (
        .clk      (clk),
        .rst      (rst),
        .load_i   (load),
        .tile_i   (tile),
        .fine_x_i (fine_x),
        .active_i (active),
        .pix_o    (pix)
    );

    palette_out u_palette (
        .clk         (clk),
        .rst         (rst),
        .pix_i       (pix),
        .pal_i       (pal),
        .pal_rdata_o (pal_rdata),
        .px_data_o   (px_data_o),
        .px_valid_o  (px_valid_o)
    );

endmodule

// File: render/bg_fetch.sv
`timescale 1ns/1ps
`include "ppu_macros.svh"

module bg_fetch import ppu_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  ppu_vaddr_u   v_i,
    input  logic [7:0]   ctrl_i,
    input  logic [7:0]   mask_i,
    input  logic [7:0]   vram_data_i,
    output fetch_req_t   fetch_o,
    output scroll_step_t step_o,
    output logic         load_o,
    output bg_tile_t     tile_o,
    output logic         active_o,
    output logic         vblank_o
);
    logic [8:0] dot_q;
    logic [8:0] line_q;
    logic [7:0] tile_idx_q;
    logic [2:0] phase;
    logic [1:0] quad;
    logic       render_en;
    logic       vis_line;
    logic       render_line;
    logic       fetch_dot;
    logic       fetching;

    always_ff @(posedge clk) begin
        if (rst) begin
            dot_q    <= 9'd0;
            line_q   <= 9'd0;
            vblank_o <= 1'b0;
        end else begin
            if (dot_q == `PPU_DOTS - 1) begin
                dot_q  <= 9'd0;
                line_q <= (line_q == `PPU_LINES - 1) ? 9'd0 : line_q + 9'd1;
            end else begin
                dot_q <= dot_q + 9'd1;
            end
            // high from (241,1) up to (261,1)
            if (line_q == `PPU_VBL_LINE && dot_q == 9'd0) begin
                vblank_o <= 1'b1;
            end else if (line_q == `PPU_PRE_LINE && dot_q == 9'd0) begin
                vblank_o <= 1'b0;
            end
        end
    end

    assign phase       = dot_q[2:0];
    assign render_en   = mask_i[`PPU_MASK_BG];
    assign vis_line    = line_q < `PPU_VIS_H;
    assign render_line = render_en && (vis_line || line_q == `PPU_PRE_LINE);
    assign fetch_dot   = (dot_q >= 9'd1 && dot_q <= `PPU_VIS_W) ||
                         (dot_q >= `PPU_PREF_START && dot_q <= `PPU_PREF_END);
    assign fetching    = render_line && fetch_dot;

    // nt on 1, attr on 3, pattern planes on 5 and 7
    assign fetch_o.nt       = fetching && phase == 3'd1;
    assign fetch_o.attr     = fetching && phase == 3'd3;
    assign fetch_o.pat      = fetching && phase[2] && phase[0];
    assign fetch_o.pat_addr = {1'b0, ctrl_i[`PPU_CTRL_BGPT], tile_idx_q, phase[1], v_i.s.fine_y};

    assign step_o.inc_x   = fetching && phase == 3'd0;  // end of each tile
    assign step_o.inc_y   = render_line && dot_q == `PPU_VIS_W;
    assign step_o.reset_x = render_line && dot_q == `PPU_VIS_W + 1;
    assign step_o.reset_y = render_en && line_q == `PPU_PRE_LINE &&
                            dot_q >= `PPU_VRST_START && dot_q <= `PPU_VRST_END;

    assign load_o   = step_o.inc_x;
    assign active_o = render_en && vis_line && dot_q >= 9'd1 && dot_q <= `PPU_VIS_W;

    // 2x2 tile quadrant inside the 32x32 attribute area
    assign quad = {v_i.s.coarse_y[1], v_i.s.coarse_x[1]};

    always_ff @(posedge clk) begin
        if (fetch_o.nt) tile_idx_q <= vram_data_i;
        if (fetch_o.attr) tile_o.attr <= vram_data_i[{quad, 1'b0} +: 2];
        if (fetch_o.pat) begin
            if (phase[1]) begin
                tile_o.hi <= vram_data_i;
            end else begin
                tile_o.lo <= vram_data_i;
            end
        end
    end

endmodule

// File: render/bg_shifter.sv
`timescale 1ns/1ps

module bg_shifter import ppu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       load_i,
    input  bg_tile_t   tile_i,
    input  logic [2:0] fine_x_i,
    input  logic       active_i,
    output bg_pix_t    pix_o
);
    logic [15:0] pat_lo_q;
    logic [15:0] pat_hi_q;
    logic [15:0] at_lo_q;
    logic [15:0] at_hi_q;
    logic [3:0]  bit_sel;
    logic [3:0]  idx;

    // shift by one when active, new byte into the low half on load
    function automatic logic [15:0] next_sr(input logic [15:0] cur, input logic [7:0] nb,
                                            input logic ld, input logic act);
        logic [15:0] res;
        res = cur;
        if (ld && act) begin
            res = {cur[14:7], nb};
        end else if (ld) begin
            res = {cur[7:0], nb};  // prefetch, no pixels going out
        end else if (act) begin
            res = {cur[14:0], 1'b0};
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        pat_lo_q <= next_sr(pat_lo_q, tile_i.lo, load_i, active_i);
        pat_hi_q <= next_sr(pat_hi_q, tile_i.hi, load_i, active_i);
        at_lo_q  <= next_sr(at_lo_q, {8{tile_i.attr[0]}}, load_i, active_i);
        at_hi_q  <= next_sr(at_hi_q, {8{tile_i.attr[1]}}, load_i, active_i);
    end

    assign bit_sel = 4'd15 - {1'b0, fine_x_i};
    assign idx     = {at_hi_q[bit_sel], at_lo_q[bit_sel], pat_hi_q[bit_sel], pat_lo_q[bit_sel]};

    always_ff @(posedge clk) begin
        if (rst) begin
            pix_o <= '0;
        end else begin
            pix_o.valid <= active_i;
            pix_o.idx   <= {1'b0, idx};  // background half of the palette
        end
    end

endmodule

// File: run.sh
#!/bin/sh
# build and run the PPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f vlog.f --top-module ppu_tb -o ppu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/ppu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi
exit 0

// File: sim/ppu_props.sv
`timescale 1ns/1ps
`include "ppu_macros.svh"

module ppu_props import ppu_pkg::*; (
    input logic       clk,
    input logic       rst,
    input vram_bus_t  vram_o,
    input fetch_req_t fetch_i,
    input logic       vblank_i,
    input logic       nmi_o
);

    // cpu writes never land on a render fetch slot
    a_wr_no_fetch: assert property (@(posedge clk) disable iff (rst)
        vram_o.wr |-> !(fetch_i.nt || fetch_i.attr || fetch_i.pat))
        else $error("memory write strobe during a background fetch");

    a_nmi_in_vbl: assert property (@(posedge clk) disable iff (rst)
        $rose(nmi_o) |-> vblank_i)
        else $error("nmi_o rose outside vertical blank");

    a_wr_pulse: assert property (@(posedge clk) disable iff (rst)
        vram_o.wr |=> !vram_o.wr)   // single cycle strobe
        else $error("memory write strobe longer than one cycle");

endmodule

bind ppu_regs ppu_props u_props (
    .clk      (clk),
    .rst      (rst),
    .vram_o   (vram_o),
    .fetch_i  (fetch_i),
    .vblank_i (vblank_i),
    .nmi_o    (nmi_o)
);

// File: sim/ppu_tb.sv
`timescale 1ns/1ps
`include "ppu_macros.svh"

module ppu_tb import ppu_pkg::*; ();
    localparam int CLK_NS     = 4;
    localparam int FRAME_CLKS = `PPU_DOTS * `PPU_LINES;
    localparam int NPIX       = `PPU_VIS_W * `PPU_VIS_H;

    logic       clk;
    logic       rst;
    cpu_bus_t   cpu_i;
    logic [7:0] cpu_data;
    vram_bus_t  vram_o;
    logic [7:0] vram_data;
    logic [7:0] px_data;
    logic       px_valid;
    logic       nmi;
    logic       vblank;

    logic [7:0] mem [16384];    // 16 KB video memory model
    logic [7:0] pal_ref [32];   // expected palette, by physical slot
    vram_bus_t  exp_wr_q [$];
    int         pix_count = 0;

    ppu_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .cpu_i       (cpu_i),
        .cpu_data_o  (cpu_data),
        .vram_o      (vram_o),
        .vram_data_i (vram_data),
        .px_data_o   (px_data),
        .px_valid_o  (px_valid),
        .nmi_o       (nmi),
        .vblank_o    (vblank)
    );

    assign vram_data = mem[vram_o.addr];

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
        if (got !== exp) begin
            fail_stop($sformatf("FAILED at %0t: %s gave %02h, expected %02h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_vram(input vram_bus_t got, input vram_bus_t exp);
        if (got !== exp) begin
            fail_stop($sformatf("FAILED at %0t: memory write %04h=%02h, expected %04h=%02h",
                                $time, got.addr, got.wdata, exp.addr, exp.wdata));
        end
    endtask

    task automatic check_pixel(input logic [7:0] got, input logic [7:0] exp,
                               input int x, input int y);
        if (got !== exp) begin
            fail_stop($sformatf("FAILED at %0t: pixel (%0d,%0d) is %02h, expected %02h",
                                $time, x, y, got, exp));
        end
    endtask

    // one register access on a rising select, result sampled mid cycle
    task automatic bus_cycle(input logic rw, input ppu_reg_e a, input logic [7:0] d,
                             output logic [7:0] q);
        @(posedge clk);
        cpu_i <= '{cs: 1'b1, rw: rw, addr: a, wdata: d};
        @(posedge clk);   // edge seen here
        @(negedge clk);
        q = cpu_data;
        @(posedge clk);
        cpu_i.cs <= 1'b0;
    endtask

    function automatic logic [7:0] mem_at(input int a);
        return mem[14'(a)];
    endfunction

    // 10/14/18/1C share storage with 00/04/08/0C
    function automatic logic [4:0] pal_slot(input logic [4:0] a);
        logic [4:0] s;
        s = a;
        if (a[4] && a[1:0] == 2'b00) s = a - 5'd16;
        return s;
    endfunction

    // nametable 0, zero scroll, pattern table 0
    function automatic logic [7:0] ref_pixel(input int x, input int y);
        logic [7:0] tile;
        logic [7:0] attr;
        logic [7:0] lo;
        logic [7:0] hi;
        logic [1:0] pal_hi;
        logic [4:0] idx;
        int         shift;
        tile   = mem_at('h2000 + (y / 8) * 32 + x / 8);
        attr   = mem_at('h23C0 + (y / 32) * 8 + x / 32);
        shift  = ((y / 16) % 2) * 4 + ((x / 16) % 2) * 2;
        pal_hi = 2'(attr >> shift);
        lo     = mem_at(int'(tile) * 16 + y % 8);
        hi     = mem_at(int'(tile) * 16 + y % 8 + 8);
        idx    = {1'b0, pal_hi, hi[3'(7 - x % 8)], lo[3'(7 - x % 8)]};
        if (idx[1:0] == 2'b00) idx = 5'd0;  // transparent shows backdrop
        return pal_ref[idx];
    endfunction

    // memory model write port and bus check
    always @(negedge clk) begin
        if (vram_o.wr) begin
            if (exp_wr_q.size() == 0) begin
                fail_stop("a memory write appeared where none was expected");
            end else begin
                check_vram(vram_o, exp_wr_q.pop_front());
                mem[vram_o.addr] = vram_o.wdata;
            end
        end
    end

    always @(negedge clk) begin
        if (px_valid) begin
            if (pix_count >= NPIX) begin
                fail_stop("more valid pixels arrived than one frame holds");
            end else begin
                check_pixel(px_data, ref_pixel(pix_count % 256, pix_count / 256),
                            pix_count % 256, pix_count / 256);
                pix_count++;
            end
        end
    end

    initial begin
        #(CLK_NS * (4 * FRAME_CLKS + 4000));
        fail_stop("watchdog expired before the tests finished");
    end

    initial begin
        logic [7:0] d;
        logic [7:0] q;
        vram_bus_t  w;
        void'($urandom(35));
        rst   = 1'b1;
        cpu_i = '0;
        for (int i = 0; i < 16384; i++) mem[i] = 8'(i) ^ 8'(i >> 6);
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // DATA writes step by 1, then by 32
        bus_cycle(1'b0, REG_CTRL, 8'h00, q);
        bus_cycle(1'b0, REG_ADDR, 8'h24, q);
        bus_cycle(1'b0, REG_ADDR, 8'h00, q);
        for (int i = 0; i < 8; i++) begin
            d = 8'($urandom);
            w = '{addr: 14'h2400 + 14'(i), rd: 1'b0, wr: 1'b1, wdata: d};
            exp_wr_q.push_back(w);
            bus_cycle(1'b0, REG_DATA, d, q);
        end
        bus_cycle(1'b0, REG_CTRL, 8'h04, q);
        bus_cycle(1'b0, REG_ADDR, 8'h25, q);
        bus_cycle(1'b0, REG_ADDR, 8'h00, q);
        for (int i = 0; i < 4; i++) begin
            d = 8'($urandom);
            w = '{addr: 14'h2500 + 14'(32 * i), rd: 1'b0, wr: 1'b1, wdata: d};
            exp_wr_q.push_back(w);
            bus_cycle(1'b0, REG_DATA, d, q);
        end
        @(negedge clk);
        if (exp_wr_q.size() != 0) fail_stop("some DATA writes never reached the memory bus");

        // buffered reads lag by one
        bus_cycle(1'b0, REG_CTRL, 8'h00, q);
        bus_cycle(1'b0, REG_ADDR, 8'h24, q);
        bus_cycle(1'b0, REG_ADDR, 8'h00, q);
        bus_cycle(1'b1, REG_DATA, 8'h00, q);
        check_byte(q, 8'h00, "first DATA read");   // buffer never loaded yet
        for (int i = 0; i < 8; i++) begin
            bus_cycle(1'b1, REG_DATA, 8'h00, q);
            check_byte(q, mem_at('h2400 + i), "buffered DATA read");
        end

        // vblank interrupt and status
        bus_cycle(1'b0, REG_CTRL, 8'h80, q);
        while (!nmi) @(negedge clk);
        if (!vblank) fail_stop("nmi_o rose outside vertical blank");
        bus_cycle(1'b0, REG_OAMADDR, 8'h15, q);   // sets the open bus low bits
        bus_cycle(1'b1, REG_STATUS, 8'h00, q);
        check_byte(q, 8'h95, "status read in vblank");
        if (nmi) fail_stop("nmi_o stayed high after a status read");
        bus_cycle(1'b1, REG_STATUS, 8'h00, q);
        check_byte(q, 8'h15, "second status read");

        // palette through DATA while in vblank
        bus_cycle(1'b0, REG_ADDR, 8'h3F, q);
        bus_cycle(1'b0, REG_ADDR, 8'h00, q);
        for (int i = 0; i < 32; i++) begin
            d = 8'($urandom);
            pal_ref[pal_slot(5'(i))] = d;
            bus_cycle(1'b0, REG_DATA, d, q);
        end
        bus_cycle(1'b0, REG_ADDR, 8'h3F, q);
        bus_cycle(1'b0, REG_ADDR, 8'h00, q);
        for (int i = 0; i < 32; i++) begin
            bus_cycle(1'b1, REG_DATA, 8'h00, q);
            check_byte(q, pal_ref[pal_slot(5'(i))], "palette read");
        end
        if (!vblank) fail_stop("vertical blank ended before the palette checks finished");

        // random tiles, then one full frame of background
        for (int i = 0; i < 'h1000; i++) mem[14'(i)] = 8'($urandom);
        for (int i = 'h2000; i < 'h2400; i++) mem[14'(i)] = 8'($urandom);
        bus_cycle(1'b0, REG_CTRL, 8'h00, q);
        bus_cycle(1'b0, REG_SCROLL, 8'h00, q);
        bus_cycle(1'b0, REG_SCROLL, 8'h00, q);
        bus_cycle(1'b0, REG_MASK, 8'h08, q);
        if (!vblank) fail_stop("rendering was enabled after vertical blank ended");
        while (pix_count < NPIX) @(negedge clk);

        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+common
common/ppu_pkg.sv
hdl/ppu_regs.sv
render/bg_fetch.sv
render/bg_shifter.sv
hdl/palette_out.sv
hdl/ppu_top.sv
sim/ppu_props.sv
sim/ppu_tb.sv
